/* filelist.f */
mldsa_params_pkg.sv
masked_mult_pkg.sv
mod_q_reducer.sv
share_product_unit.sv
share_refresh.sv
mult_ctrl_regs.sv
masked_mult_top.sv
masked_mult_assertions.sv
tb_masked_mult.sv

/* run.sh */
#!/bin/sh
# Build and run the masked multiplier testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal --top-module tb_masked_mult -f filelist.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/Vtb_masked_mult)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "TEST PASSED"; then
    exit 0
fi
exit 1

/* tb_masked_mult.sv */
// Testbench for the masked modular multiplier
// Table of tests applied in a loop, LFSR shares and masks,
// reference model, result checker and watchdog

`timescale 1ns/100ps

module tb_masked_mult;
    import mldsa_params_pkg::*;
    import masked_mult_pkg::*;

    localparam int     N_TESTS = 4;
    localparam longint QL      = longint'(MLDSA_Q);

    // Test table with name, operations, refresh, back-to-back strobes and corner operands
    string names  [N_TESTS] = '{"random_refresh", "corner_operands", "refresh_off",
                                "back_to_back"};
    int    n_ops  [N_TESTS] = '{16, 9, 12, 20};
    bit    refr   [N_TESTS] = '{1'b1, 1'b1, 1'b0, 1'b1};
    bit    b2b    [N_TESTS] = '{1'b0, 1'b0, 1'b0, 1'b1};
    bit    corner [N_TESTS] = '{1'b0, 1'b1, 1'b0, 1'b0};

    logic                  clk = 1'b0;
    logic                  reset_n;
    logic                  in_valid;
    logic [COEFF_W-1:0]    u0, u1, v0, v1;
    logic [COEFF_W-1:0]    rnd_cross;
    logic [COEFF_W-1:0]    rnd_refresh;
    logic                  out_valid;
    logic [COEFF_W-1:0]    z0, z1;
    logic                  reg_wr;
    logic [REG_ADDR_W-1:0] reg_addr;
    logic [REG_DATA_W-1:0] reg_wdata;
    logic [REG_DATA_W-1:0] reg_rdata;

    // Expected results queued at issue
    logic [COEFF_W-1:0] exp_z0    [$];
    logic [COEFF_W-1:0] exp_z1    [$];
    longint             exp_prod  [$];
    int                 exp_cycle [$];

    logic [31:0] lfsr      = 32'h0ce6e414;
    int          cycle     = 0;
    int          errors    = 0;
    int          delivered = 0;
    int          issued    = 0;

    masked_mult_top masked_mult_top_i (
        .clk         (clk),
        .reset_n     (reset_n),
        .in_valid    (in_valid),
        .u0          (u0),
        .u1          (u1),
        .v0          (v0),
        .v1          (v1),
        .rnd_cross   (rnd_cross),
        .rnd_refresh (rnd_refresh),
        .out_valid   (out_valid),
        .z0          (z0),
        .z1          (z1),
        .reg_wr      (reg_wr),
        .reg_addr    (reg_addr),
        .reg_wdata   (reg_wdata),
        .reg_rdata   (reg_rdata)
    );

    always #5 clk = ~clk;

    always @(posedge clk)
        cycle <= cycle + 1;

    //==========================================================================
    // Reference model and stimulus helpers
    //==========================================================================
    // Fibonacci LFSR with taps 32 22 2 1 and 22 bits per value to stay below q
    function automatic logic [COEFF_W-1:0] draw_value();
        logic [COEFF_W-1:0] val;
        val = '0;
        for (int i = 0; i < COEFF_W - 1; i++) begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            val  = {val[COEFF_W-2:0], lfsr[0]};
        end
        return val;
    endfunction

    function automatic logic [COEFF_W-1:0] corner_value(input int sel);
        case (sel)
            0:       return '0;
            1:       return COEFF_W'(1);
            default: return MLDSA_Q - COEFF_W'(1);
        endcase
    endfunction

    function automatic longint mulq(input longint a, input longint b);
        return (a * b) % QL;
    endfunction

    function automatic int run_budget();
        int total;
        // Reset, register accesses and the zeroize step
        total = 30 + 3 + PIPE_LAT + 10;
        for (int t = 0; t < N_TESTS; t++)
            total += n_ops[t] * (b2b[t] ? 1 : 2) + PIPE_LAT + 10;
        return total;
    endfunction

    task automatic compare(input string name, input longint got, input longint exp);
        if (got != exp) begin
            $display("FAIL time %0t signal %s got %0d expected %0d", $time, name, got, exp);
            errors++;
        end
    endtask

    // Called on a falling edge and returns on the next one
    task automatic issue_op(input int t, input int k);
        logic [COEFF_W-1:0] a0, a1, b0, b1, rc, rr;
        longint             d0e, d1e;
        if (corner[t]) begin
            a0 = corner_value(k % 3);
            a1 = corner_value(k / 3);
            b0 = corner_value((k + 1) % 3);
            b1 = corner_value((k / 3 + 2) % 3);
        end else begin
            a0 = draw_value();
            a1 = draw_value();
            b0 = draw_value();
            b1 = draw_value();
        end
        rc = draw_value();
        rr = draw_value();
        // Domain 0 adds the cross mask and domain 1 takes it away
        d0e = (mulq(longint'(a0), longint'(b0)) + mulq(longint'(a0), longint'(b1))
               + longint'(rc)) % QL;
        d1e = (mulq(longint'(a1), longint'(b1)) + mulq(longint'(a1), longint'(b0))
               + QL - longint'(rc)) % QL;
        if (refr[t]) begin
            d0e = (d0e + longint'(rr)) % QL;
            d1e = (d1e + QL - longint'(rr)) % QL;
        end
        exp_z0.push_back(COEFF_W'(d0e));
        exp_z1.push_back(COEFF_W'(d1e));
        exp_prod.push_back(mulq(longint'(a0) + longint'(a1), longint'(b0) + longint'(b1)));
        exp_cycle.push_back(cycle);
        issued++;
        in_valid    = 1'b1;
        u0          = a0;
        u1          = a1;
        v0          = b0;
        v1          = b1;
        rnd_cross   = rc;
        rnd_refresh = rr;
        @(negedge clk);
        in_valid = 1'b0;
    endtask

    task automatic write_ctrl(input bit refresh, input bit zero);
        reg_wdata                   = '0;
        reg_wdata[CTRL_REFRESH_BIT] = refresh;
        reg_wdata[CTRL_ZEROIZE_BIT] = zero;
        reg_addr                    = ADDR_CTRL;
        reg_wr                      = 1'b1;
        @(negedge clk);
        reg_wr = 1'b0;
    endtask

    task automatic check_reg(input logic [REG_ADDR_W-1:0] addr, input longint exp);
        reg_addr = addr;
        #1;
        compare("reg_rdata", longint'(reg_rdata), exp);
        @(negedge clk);
    endtask

    task automatic drain();
        while (exp_z0.size() != 0)
            @(posedge clk);
        @(negedge clk);
    endtask

    //==========================================================================
    // Result checker sampling outputs on the falling edge
    //==========================================================================
    always @(negedge clk) begin
        if (reset_n && out_valid) begin
            delivered++;
            if (exp_z0.size() == 0) begin
                $display("ERROR at %0t: out_valid with no operation in flight", $time);
                errors++;
            end else begin
                compare("z0", longint'(z0), longint'(exp_z0.pop_front()));
                compare("z1", longint'(z1), longint'(exp_z1.pop_front()));
                compare("z0+z1", (longint'(z0) + longint'(z1)) % QL, exp_prod.pop_front());
                compare("latency", longint'(cycle - exp_cycle.pop_front()),
                        longint'(PIPE_LAT));
            end
        end
    end

    initial begin
        int err_start;
        reset_n     = 1'b0;
        in_valid    = 1'b0;
        u0          = '0;
        u1          = '0;
        v0          = '0;
        v1          = '0;
        rnd_cross   = '0;
        rnd_refresh = '0;
        reg_wr      = 1'b0;
        reg_addr    = '0;
        reg_wdata   = '0;
        repeat (2) @(negedge clk);
        reset_n = 1'b1;

        check_reg(ADDR_COUNT, 0);
        check_reg(ADDR_CTRL, 1);
        $display("test reset_values: errors %0d", errors);

        for (int t = 0; t < N_TESTS; t++) begin
            err_start = errors;
            write_ctrl(refr[t], 1'b0);
            check_reg(ADDR_CTRL, longint'(refr[t]));
            for (int k = 0; k < n_ops[t]; k++) begin
                issue_op(t, k);
                if (!b2b[t])
                    @(negedge clk);
            end
            drain();
            $display("test %s: %0d operations, errors %0d", names[t], n_ops[t],
                     errors - err_start);
        end

        // Counter against operations issued and then a flush with work in flight
        err_start = errors;
        check_reg(ADDR_COUNT, issued);
        for (int k = 0; k < 3; k++)
            issue_op(0, k);
        write_ctrl(1'b1, 1'b1);
        exp_z0.delete();
        exp_z1.delete();
        exp_prod.delete();
        exp_cycle.delete();
        repeat (PIPE_LAT + 4) @(negedge clk);
        check_reg(ADDR_COUNT, 0);
        check_reg(ADDR_CTRL, 1);
        $display("test zeroize_and_count: errors %0d", errors - err_start);

        $display("summary: %0d tests, %0d results, %0d errors", N_TESTS + 2, delivered,
                 errors);
        if (errors == 0)
            $display("TEST PASSED");
        else
            $display("TEST FAILED");
        $finish;
    end

    initial begin
        int budget;
        budget = run_budget();
        repeat (budget) @(posedge clk);
        $display("Timeout: run did not finish within %0d cycles", budget);
        $display("TEST FAILED");
        $finish;
    end

endmodule

/* masked_mult_assertions.sv */
// Concurrent checks on the masked multiplier top level
// Fixed latency, output range and the zeroize flush

`timescale 1ns/100ps

module masked_mult_assertions (
    input logic                                 clk,
    input logic                                 reset_n,
    input logic                                 in_valid,
    input logic                                 zeroize,
    input logic                                 out_valid,
    input logic [mldsa_params_pkg::COEFF_W-1:0] z0,
    input logic [mldsa_params_pkg::COEFF_W-1:0] z1
);
    import mldsa_params_pkg::*;
    import masked_mult_pkg::*;

    // Zeroize history, newest in bit 0
    logic [PIPE_LAT-1:0] zero_hist;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n)
            zero_hist <= '0;
        else
            zero_hist <= {zero_hist[PIPE_LAT-2:0], zeroize};
    end

    latency_exact: assert property (@(posedge clk) disable iff (!reset_n)
        out_valid == ($past(in_valid, PIPE_LAT) && (zero_hist == '0)))
        else $error("out_valid not exactly %0d cycles after in_valid", PIPE_LAT);

    shares_in_range: assert property (@(posedge clk) disable iff (!reset_n)
        out_valid |-> (z0 < MLDSA_Q) && (z1 < MLDSA_Q))
        else $error("output share not below q");

    zeroize_flush: assert property (@(posedge clk) disable iff (!reset_n)
        zeroize |=> !out_valid)
        else $error("out_valid high after zeroize");

endmodule

bind masked_mult_top masked_mult_assertions masked_mult_assertions_i (
    .clk       (clk),
    .reset_n   (reset_n),
    .in_valid  (in_valid),
    .zeroize   (zeroize),
    .out_valid (out_valid),
    .z0        (z0),
    .z1        (z1)
);

/* masked_mult_top.sv */
// Masked modular multiplier, top level
// Control registers, share product unit and output refresh

`timescale 1ns/100ps

module masked_mult_top (
    input  logic                                   clk,
    input  logic                                   reset_n,
    input  logic                                   in_valid,
    input  logic [mldsa_params_pkg::COEFF_W-1:0]   u0,
    input  logic [mldsa_params_pkg::COEFF_W-1:0]   u1,
    input  logic [mldsa_params_pkg::COEFF_W-1:0]   v0,
    input  logic [mldsa_params_pkg::COEFF_W-1:0]   v1,
    input  logic [mldsa_params_pkg::COEFF_W-1:0]   rnd_cross,
    input  logic [mldsa_params_pkg::COEFF_W-1:0]   rnd_refresh,
    output logic                                   out_valid,
    output logic [mldsa_params_pkg::COEFF_W-1:0]   z0,
    output logic [mldsa_params_pkg::COEFF_W-1:0]   z1,
    input  logic                                   reg_wr,
    input  logic [masked_mult_pkg::REG_ADDR_W-1:0] reg_addr,
    input  logic [masked_mult_pkg::REG_DATA_W-1:0] reg_wdata,
    output logic [masked_mult_pkg::REG_DATA_W-1:0] reg_rdata
);
    import mldsa_params_pkg::*;

    logic               refresh_en;
    logic               zeroize;
    logic               d_valid;
    logic [COEFF_W-1:0] d0;
    logic [COEFF_W-1:0] d1;

    mult_ctrl_regs mult_ctrl_regs_i (
        .clk        (clk),
        .reset_n    (reset_n),
        .reg_wr     (reg_wr),
        .reg_addr   (reg_addr),
        .reg_wdata  (reg_wdata),
        .out_valid  (out_valid),
        .reg_rdata  (reg_rdata),
        .refresh_en (refresh_en),
        .zeroize    (zeroize)
    );

    share_product_unit share_product_unit_i (
        .clk       (clk),
        .reset_n   (reset_n),
        .zeroize   (zeroize),
        .in_valid  (in_valid),
        .u0        (u0),
        .u1        (u1),
        .v0        (v0),
        .v1        (v1),
        .rnd_cross (rnd_cross),
        .d_valid   (d_valid),
        .d0        (d0),
        .d1        (d1)
    );

    // Raw rnd_refresh, aligned inside the refresh unit
    share_refresh share_refresh_i (
        .clk        (clk),
        .reset_n    (reset_n),
        .zeroize    (zeroize),
        .refresh_en (refresh_en),
        .d_valid    (d_valid),
        .d0         (d0),
        .d1         (d1),
        .rnd        (rnd_refresh),
        .out_valid  (out_valid),
        .z0         (z0),
        .z1         (z1)
    );

endmodule

/* mult_ctrl_regs.sv */
// Control and status registers
// Refresh enable, self-clearing zeroize pulse, saturating result counter

`timescale 1ns/100ps

module mult_ctrl_regs (
    input  logic                                   clk,
    input  logic                                   reset_n,
    input  logic                                   reg_wr,
    input  logic [masked_mult_pkg::REG_ADDR_W-1:0] reg_addr,
    input  logic [masked_mult_pkg::REG_DATA_W-1:0] reg_wdata,
    input  logic                                   out_valid,
    output logic [masked_mult_pkg::REG_DATA_W-1:0] reg_rdata,
    output logic                                   refresh_en,
    output logic                                   zeroize
);
    import masked_mult_pkg::*;

    logic                  ctrl_wr;
    logic [REG_DATA_W-1:0] result_count;

    assign ctrl_wr = reg_wr && (reg_addr == ADDR_CTRL);

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            refresh_en <= 1'b1;
            zeroize    <= 1'b0;
        end else begin
            if (ctrl_wr)
                refresh_en <= reg_wdata[CTRL_REFRESH_BIT];
            // One-cycle pulse, the bit itself is never stored
            zeroize <= ctrl_wr && reg_wdata[CTRL_ZEROIZE_BIT];
        end
    end

    // Holds at all ones rather than wrapping
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n)
            result_count <= '0;
        else if (zeroize)
            result_count <= '0;
        else if (out_valid && (result_count != '1))
            result_count <= result_count + 1'b1;
    end

    always_comb begin
        reg_rdata = '0;
        case (reg_addr)
            ADDR_CTRL:  reg_rdata[CTRL_REFRESH_BIT] = refresh_en;
            ADDR_COUNT: reg_rdata = result_count;
            default:    reg_rdata = '0;
        endcase
    end

endmodule

/* share_refresh.sv */
// Output share refresh
// Delays the raw refresh mask to meet the domain results, then adds
// it to one share and removes it from the other

`timescale 1ns/100ps

module share_refresh (
    input  logic                                 clk,
    input  logic                                 reset_n,
    input  logic                                 zeroize,
    input  logic                                 refresh_en,
    input  logic                                 d_valid,
    input  logic [mldsa_params_pkg::COEFF_W-1:0] d0,
    input  logic [mldsa_params_pkg::COEFF_W-1:0] d1,
    input  logic [mldsa_params_pkg::COEFF_W-1:0] rnd,
    output logic                                 out_valid,
    output logic [mldsa_params_pkg::COEFF_W-1:0] z0,
    output logic [mldsa_params_pkg::COEFF_W-1:0] z1
);
    import mldsa_params_pkg::*;

    // Mask taken with in_valid, used four cycles later
    logic [COEFF_W-1:0] rnd_dly [4];

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            rnd_dly   <= '{default: '0};
            out_valid <= 1'b0;
            z0        <= '0;
            z1        <= '0;
        end else if (zeroize) begin
            rnd_dly   <= '{default: '0};
            out_valid <= 1'b0;
            z0        <= '0;
            z1        <= '0;
        end else begin
            rnd_dly[0] <= rnd;
            rnd_dly[1] <= rnd_dly[0];
            rnd_dly[2] <= rnd_dly[1];
            rnd_dly[3] <= rnd_dly[2];
            out_valid  <= d_valid;
            if (d_valid) begin
                z0 <= refresh_en ? add_mod(d0, rnd_dly[3]) : d0;
                z1 <= refresh_en ? sub_mod(d1, rnd_dly[3]) : d1;
            end
        end
    end

endmodule

/* share_product_unit.sv */
// Two-share cross multiplication
// Four products, Barrett reduction of each, domain combining with
// the cross mask; four cycles from in_valid to d_valid

`timescale 1ns/100ps

module share_product_unit (
    input  logic                                 clk,
    input  logic                                 reset_n,
    input  logic                                 zeroize,
    input  logic                                 in_valid,
    input  logic [mldsa_params_pkg::COEFF_W-1:0] u0,
    input  logic [mldsa_params_pkg::COEFF_W-1:0] u1,
    input  logic [mldsa_params_pkg::COEFF_W-1:0] v0,
    input  logic [mldsa_params_pkg::COEFF_W-1:0] v1,
    input  logic [mldsa_params_pkg::COEFF_W-1:0] rnd_cross,
    output logic                                 d_valid,
    output logic [mldsa_params_pkg::COEFF_W-1:0] d0,
    output logic [mldsa_params_pkg::COEFF_W-1:0] d1
);
    import mldsa_params_pkg::*;

    // Product order: u0*v0, u0*v1, u1*v0, u1*v1
    logic [PROD_W-1:0]  prod_q [4];
    logic [COEFF_W-1:0] prod_r [4];
    // Cross mask follows the products through multiply and reduce
    logic [COEFF_W-1:0] rnd_dly [3];
    logic [3:0]         valid_sr;

    //==========================================================================
    // Multiply stage
    //==========================================================================
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            prod_q <= '{default: '0};
        end else if (zeroize) begin
            prod_q <= '{default: '0};
        end else begin
            prod_q[0] <= u0 * v0;
            prod_q[1] <= u0 * v1;
            prod_q[2] <= u1 * v0;
            prod_q[3] <= u1 * v1;
        end
    end

    for (genvar i = 0; i < 4; i++) begin : g_reduce
        mod_q_reducer mod_q_reducer_i (
            .clk     (clk),
            .reset_n (reset_n),
            .zeroize (zeroize),
            .a       (prod_q[i]),
            .r       (prod_r[i])
        );
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            rnd_dly  <= '{default: '0};
            valid_sr <= '0;
        end else if (zeroize) begin
            rnd_dly  <= '{default: '0};
            valid_sr <= '0;
        end else begin
            rnd_dly[0] <= rnd_cross;
            rnd_dly[1] <= rnd_dly[0];
            rnd_dly[2] <= rnd_dly[1];
            valid_sr   <= {valid_sr[2:0], in_valid};
        end
    end

    //==========================================================================
    // Domain combine
    //==========================================================================
    // Domain 0 adds the mask, domain 1 removes it
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            d0 <= '0;
            d1 <= '0;
        end else if (zeroize) begin
            d0 <= '0;
            d1 <= '0;
        end else begin
            d0 <= add_mod(add_mod(prod_r[0], prod_r[1]), rnd_dly[2]);
            d1 <= sub_mod(add_mod(prod_r[3], prod_r[2]), rnd_dly[2]);
        end
    end

    assign d_valid = valid_sr[3];

endmodule

/* mod_q_reducer.sv */
// Barrett reducer for a 46-bit product modulo q
// Two register stages, result always below q

`timescale 1ns/100ps

module mod_q_reducer (
    input  logic                                 clk,
    input  logic                                 reset_n,
    input  logic                                 zeroize,
    input  logic [mldsa_params_pkg::PROD_W-1:0]  a,
    output logic [mldsa_params_pkg::COEFF_W-1:0] r
);
    import mldsa_params_pkg::*;

    // Full product a * m, 70 bits
    logic [PROD_W+COEFF_W:0] a_times_m;
    logic [COEFF_W:0]        qhat;
    logic [COEFF_W:0]        qhat_q;
    // Remainder is below 2q, so only the low bits of a are needed
    logic [COEFF_W+1:0]      a_low_q;
    logic [2*COEFF_W:0]      qhat_times_q;
    logic [COEFF_W+1:0]      diff;
    logic [COEFF_W+1:0]      diff_corr;

    //==========================================================================
    // Stage one: quotient estimate
    //==========================================================================
    always_comb begin
        a_times_m = a * BARRETT_M;
        qhat      = a_times_m[BARRETT_K +: COEFF_W+1];
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            qhat_q  <= '0;
            a_low_q <= '0;
        end else if (zeroize) begin
            qhat_q  <= '0;
            a_low_q <= '0;
        end else begin
            qhat_q  <= qhat;
            a_low_q <= a[COEFF_W+1:0];
        end
    end

    //==========================================================================
    // Stage two: subtract estimate times q, one correction
    //==========================================================================
    always_comb begin
        qhat_times_q = qhat_q * MLDSA_Q;
        diff         = a_low_q - qhat_times_q[COEFF_W+1:0];
        diff_corr    = (diff >= MLDSA_Q) ? diff - MLDSA_Q : diff;
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n)
            r <= '0;
        else if (zeroize)
            r <= '0;
        else
            r <= diff_corr[COEFF_W-1:0];
    end

endmodule

/* masked_mult_pkg.sv */
// Masked multiplier configuration
// Pipeline latency, register map and control register fields

package masked_mult_pkg;

    // Cycles from in_valid to out_valid
    localparam int PIPE_LAT = 5;

    // Register port widths
    localparam int REG_ADDR_W = 2;
    localparam int REG_DATA_W = 16;

    // Register map
    localparam logic [REG_ADDR_W-1:0] ADDR_CTRL  = 2'd0;
    localparam logic [REG_ADDR_W-1:0] ADDR_COUNT = 2'd1;

    // Control register fields
    localparam int CTRL_REFRESH_BIT = 0;
    localparam int CTRL_ZEROIZE_BIT = 1;

endpackage

/* mldsa_params_pkg.sv */
// ML-DSA arithmetic parameters
// Modulus q, coefficient and product widths, Barrett constants,
// and the modular add and subtract helpers shared by the datapath

package mldsa_params_pkg;

    localparam int COEFF_W = 23;
    localparam int PROD_W  = 46;

    localparam logic [COEFF_W-1:0] MLDSA_Q = 23'd8380417;

    // Barrett reduction, m = floor(2^k / q) with k = PROD_W
    localparam int               BARRETT_K = 46;
    localparam logic [COEFF_W:0] BARRETT_M = 24'd8396807;

    // Operands below q, one conditional correction is enough
    function automatic logic [COEFF_W-1:0] add_mod(input logic [COEFF_W-1:0] x,
                                                   input logic [COEFF_W-1:0] y);
        logic [COEFF_W:0] s;
        s = {1'b0, x} + {1'b0, y};
        if (s >= MLDSA_Q)
            s = s - MLDSA_Q;
        return s[COEFF_W-1:0];
    endfunction

    function automatic logic [COEFF_W-1:0] sub_mod(input logic [COEFF_W-1:0] x,
                                                   input logic [COEFF_W-1:0] y);
        logic [COEFF_W:0] d;
        d = {1'b0, x} - {1'b0, y};
        // Top bit set means the difference went negative
        if (d[COEFF_W])
            d = d + MLDSA_Q;
        return d[COEFF_W-1:0];
    endfunction

endpackage
